/* design/core_control.sv */
/*
  Multi-cycle RV32 core, one instruction at a time.
  Fetch and data accesses share one memory port and may wait any number
  of cycles for a grant. The PC starts at 0 and the core leaves IDLE on run.
  ECALL raises halt, which holds until reset.
*/
`timescale 1ns/1ps

module core_control (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,
  output logic              halt,
  output logic              core_req,
  output logic              core_we,
  output rv_isa_pkg::word_t core_addr,
  output rv_isa_pkg::word_t core_wdata,
  input  logic              core_gnt,
  input  logic              core_rvalid,
  input  rv_isa_pkg::word_t mem_rdata
);
  typedef enum logic [2:0] {
    IDLE, FETCH_REQ, FETCH_WAIT, EXECUTE, DATA_REQ, LOAD_WAIT, DIVIDE, HALTED
  } state_t;

  state_t                state;
  rv_isa_pkg::word_t     pc;
  rv_isa_pkg::insn_t     ir;
  rv_isa_pkg::reg_addr_t rs1;
  rv_isa_pkg::reg_addr_t rs2;
  rv_isa_pkg::reg_addr_t rd;
  rv_isa_pkg::word_t     imm;
  rv_isa_pkg::op_t       op;
  rv_isa_pkg::word_t     rs1_data;
  rv_isa_pkg::word_t     rs2_data;
  rv_isa_pkg::word_t     alu_result;
  rv_isa_pkg::word_t     rf_wdata;
  rv_isa_pkg::word_t     pc_plus4;
  rv_isa_pkg::word_t     next_pc;
  rv_isa_pkg::word_t     div_result;
  logic                  rf_we;
  logic                  writes_rd;
  logic                  is_div;
  logic                  div_done;

  insn_decode u_decode (
    .insn(ir), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .op(op)
  );

  reg_file u_regs (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .we(rf_we), .rd(rd), .rd_data(rf_wdata)
  );

  // Operands are sampled by the divider in the EXECUTE cycle.
  divider u_div (
    .clk(clk), .rst(rst), .start(state == EXECUTE && is_div),
    .is_signed(op == rv_isa_pkg::OPN_DIV || op == rv_isa_pkg::OPN_REM),
    .want_rem(op == rv_isa_pkg::OPN_REM || op == rv_isa_pkg::OPN_REMU),
    .dividend(rs1_data), .divisor(rs2_data), .done(div_done), .result(div_result)
  );

  // --------------------
  // ALU and branch target.
  assign is_div   = op inside {rv_isa_pkg::OPN_DIV, rv_isa_pkg::OPN_DIVU,
                               rv_isa_pkg::OPN_REM, rv_isa_pkg::OPN_REMU};
  assign pc_plus4 = pc + 32'd4;
  assign next_pc  = (op == rv_isa_pkg::OPN_JAL ||
                     (op == rv_isa_pkg::OPN_BEQ && rs1_data == rs2_data)) ? pc + imm : pc_plus4;

  always_comb begin
    alu_result = '0;
    writes_rd  = 1'b1;
    case (op)
      rv_isa_pkg::OPN_LUI:  alu_result = imm;
      rv_isa_pkg::OPN_ADDI: alu_result = rs1_data + imm;
      rv_isa_pkg::OPN_ADD:  alu_result = rs1_data + rs2_data;
      rv_isa_pkg::OPN_SUB:  alu_result = rs1_data - rs2_data;
      // JAL links the address after itself.
      rv_isa_pkg::OPN_JAL:  alu_result = pc_plus4;
      default:              writes_rd  = 1'b0;
    endcase
  end

  // Write back from the ALU, the load data or the divider.
  always_comb begin
    rf_we    = 1'b0;
    rf_wdata = alu_result;
    case (state)
      EXECUTE: rf_we = writes_rd;
      LOAD_WAIT: begin
        rf_we    = core_rvalid;
        rf_wdata = mem_rdata;
      end
      DIVIDE: begin
        rf_we    = div_done;
        rf_wdata = div_result;
      end
      default: rf_we = 1'b0;
    endcase
  end

  // --------------------
  // Memory requests. The request level holds until the grant.
  assign core_req   = (state == FETCH_REQ) || (state == DATA_REQ);
  assign core_we    = (state == DATA_REQ) && (op == rv_isa_pkg::OPN_SW);
  assign core_addr  = (state == DATA_REQ) ? rs1_data + imm : pc;
  assign core_wdata = rs2_data;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
      pc    <= '0;
      halt  <= 1'b0;
    end else begin
      case (state)
        IDLE:       if (run) state <= FETCH_REQ;
        FETCH_REQ:  if (core_gnt) state <= FETCH_WAIT;
        FETCH_WAIT: if (core_rvalid) state <= EXECUTE;
        EXECUTE: begin
          if (op == rv_isa_pkg::OPN_HALT) begin
            halt  <= 1'b1;
            state <= HALTED;
          end else if (op == rv_isa_pkg::OPN_LW || op == rv_isa_pkg::OPN_SW) begin
            state <= DATA_REQ;
          end else if (is_div) begin
            state <= DIVIDE;
          end else begin
            pc    <= next_pc;
            state <= FETCH_REQ;
          end
        end
        DATA_REQ: begin
          // A store is done once granted, a load waits for its data.
          if (core_gnt && op == rv_isa_pkg::OPN_SW) begin
            pc    <= pc_plus4;
            state <= FETCH_REQ;
          end else if (core_gnt) begin
            state <= LOAD_WAIT;
          end
        end
        LOAD_WAIT, DIVIDE: begin
          if ((state == LOAD_WAIT && core_rvalid) || (state == DIVIDE && div_done)) begin
            pc    <= pc_plus4;
            state <= FETCH_REQ;
          end
        end
        HALTED:  state <= HALTED;
        default: state <= IDLE;
      endcase
    end
  end

  // Instruction register.
  always_ff @(posedge clk) begin
    if (state == FETCH_WAIT && core_rvalid) ir <= mem_rdata;
  end

endmodule

/* design/cpu_top.sv */
/*
  Top level of the processor with its unified memory.
  The host loads a program through the external port before run and reads
  results after halt. The external port has priority over the core.
*/
`timescale 1ns/1ps

module cpu_top #(
  parameter int MEM_WORDS = 1024
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              run,
  output logic              halt,
  input  logic              ext_req,
  input  logic              ext_we,
  input  rv_isa_pkg::word_t ext_addr,
  input  rv_isa_pkg::word_t ext_wdata,
  output logic              ext_gnt,
  output logic              ext_rvalid,
  output rv_isa_pkg::word_t ext_rdata
);
  // Core side of the arbiter.
  logic              core_req;
  logic              core_we;
  rv_isa_pkg::word_t core_addr;
  rv_isa_pkg::word_t core_wdata;
  logic              core_gnt;
  logic              core_rvalid;

  // Memory side.
  logic              mem_en;
  logic              mem_we;
  rv_isa_pkg::word_t mem_addr;
  rv_isa_pkg::word_t mem_wdata;
  rv_isa_pkg::word_t mem_rdata;

  // Read data is shared by both peers.
  assign ext_rdata = mem_rdata;

  core_control u_core (
    .clk(clk), .rst(rst), .run(run), .halt(halt),
    .core_req(core_req), .core_we(core_we),
    .core_addr(core_addr), .core_wdata(core_wdata),
    .core_gnt(core_gnt), .core_rvalid(core_rvalid), .mem_rdata(mem_rdata)
  );

  mem_arbiter u_arb (
    .clk(clk), .rst(rst),
    .ext_req(ext_req), .ext_we(ext_we), .ext_addr(ext_addr), .ext_wdata(ext_wdata),
    .ext_gnt(ext_gnt), .ext_rvalid(ext_rvalid),
    .core_req(core_req), .core_we(core_we), .core_addr(core_addr),
    .core_wdata(core_wdata), .core_gnt(core_gnt), .core_rvalid(core_rvalid),
    .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
  );

  unified_mem #(
    .MEM_WORDS(MEM_WORDS)
  ) u_mem (
    .clk(clk), .mem_en(mem_en), .mem_we(mem_we),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
  );

endmodule

/* design/divider.sv */
/*
  Iterative restoring divider, one quotient bit per cycle.
  done pulses exactly 32 cycles after start, with result valid in that cycle.
  start is ignored by the caller while busy. Signed ops divide magnitudes.
  Divide by zero gives all ones and a remainder equal to the dividend.
*/
`timescale 1ns/1ps

module divider (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  logic              is_signed,
  input  logic              want_rem,
  input  rv_isa_pkg::word_t dividend,
  input  rv_isa_pkg::word_t divisor,
  output logic              done,
  output rv_isa_pkg::word_t result
);
  rv_isa_pkg::word_t abs_dividend;
  rv_isa_pkg::word_t abs_divisor;
  rv_isa_pkg::word_t rem_q;
  rv_isa_pkg::word_t quo_q;
  rv_isa_pkg::word_t dvsr_q;
  rv_isa_pkg::word_t step_rem;
  rv_isa_pkg::word_t step_quo;
  rv_isa_pkg::word_t step_dvsr;
  rv_isa_pkg::word_t next_rem;
  rv_isa_pkg::word_t next_quo;
  logic [32:0]       shifted;
  logic [32:0]       trial;
  logic [4:0]        step_cnt;
  logic              busy;
  logic              neg_quo;
  logic              neg_rem;
  logic              div_zero;
  logic              rem_sel;

  assign abs_dividend = (is_signed && dividend[31]) ? -dividend : dividend;
  assign abs_divisor  = (is_signed && divisor[31])  ? -divisor  : divisor;

  // --------------------
  // One restoring step.
  // The first step runs on the start edge, straight from the magnitudes.
  assign step_rem  = start ? '0 : rem_q;
  assign step_quo  = start ? abs_dividend : quo_q;
  assign step_dvsr = start ? abs_divisor : dvsr_q;
  assign shifted   = {step_rem, step_quo[31]};
  assign trial     = shifted - {1'b0, step_dvsr};
  // Negative trial means restore and shift in a zero.
  assign next_rem  = trial[32] ? shifted[31:0] : trial[31:0];
  assign next_quo  = {step_quo[30:0], ~trial[32]};

  // Step counter. Count 31 is the last of the 32 steps.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy     <= 1'b0;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy     <= 1'b1;
        step_cnt <= 5'd1;
      end else if (busy) begin
        step_cnt <= step_cnt + 5'd1;
        if (step_cnt == 5'd31) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // Working values and the sign rules of the operation.
  always_ff @(posedge clk) begin
    if (start || busy) begin
      rem_q <= next_rem;
      quo_q <= next_quo;
    end
    if (start) begin
      dvsr_q   <= abs_divisor;
      neg_quo  <= is_signed && (dividend[31] ^ divisor[31]);
      neg_rem  <= is_signed && dividend[31];
      div_zero <= (divisor == '0);
      rem_sel  <= want_rem;
    end
  end

  // Remainder follows the dividend sign, which also covers divide by zero.
  always_comb begin
    if (rem_sel) begin
      result = neg_rem ? -rem_q : rem_q;
    end else if (div_zero) begin
      result = '1;
    end else begin
      result = neg_quo ? -quo_q : quo_q;
    end
  end

endmodule

/* design/insn_decode.sv */
/*
  Instruction decoder for the RV32 subset.
  Pure combinational. Unsupported encodings map to OPN_NOP.
  The immediate format is chosen from the opcode and is sign-extended.
*/
`timescale 1ns/1ps

module insn_decode (
  input  rv_isa_pkg::insn_t     insn,
  output rv_isa_pkg::reg_addr_t rs1,
  output rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::reg_addr_t rd,
  output rv_isa_pkg::word_t     imm,
  output rv_isa_pkg::op_t       op
);
  rv_isa_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];
  assign rd     = insn[11:7];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];

  always_comb begin
    op  = rv_isa_pkg::OPN_NOP;
    imm = '0;
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        op  = rv_isa_pkg::OPN_LUI;
        imm = {insn[31:12], 12'b0};
      end
      rv_isa_pkg::OP_REG_IMM: begin
        // Only ADDI among the immediate ALU ops.
        imm = {{20{insn[31]}}, insn[31:20]};
        if (funct3 == 3'b000) op = rv_isa_pkg::OPN_ADDI;
      end
      rv_isa_pkg::OP_REG_REG: begin
        if (funct7 == rv_isa_pkg::FUNCT7_MULDIV) begin
          // Divide group, funct3 100 to 111. MUL is not supported.
          case (funct3)
            3'b100:  op = rv_isa_pkg::OPN_DIV;
            3'b101:  op = rv_isa_pkg::OPN_DIVU;
            3'b110:  op = rv_isa_pkg::OPN_REM;
            3'b111:  op = rv_isa_pkg::OPN_REMU;
            default: op = rv_isa_pkg::OPN_NOP;
          endcase
        end else if (funct3 == 3'b000 && funct7 == 7'd0) begin
          op = rv_isa_pkg::OPN_ADD;
        end else if (funct3 == 3'b000 && funct7 == rv_isa_pkg::FUNCT7_SUB) begin
          op = rv_isa_pkg::OPN_SUB;
        end
      end
      rv_isa_pkg::OP_LOAD: begin
        imm = {{20{insn[31]}}, insn[31:20]};
        if (funct3 == 3'b010) op = rv_isa_pkg::OPN_LW;
      end
      rv_isa_pkg::OP_STORE: begin
        imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
        if (funct3 == 3'b010) op = rv_isa_pkg::OPN_SW;
      end
      rv_isa_pkg::OP_BRANCH: begin
        imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
        if (funct3 == 3'b000) op = rv_isa_pkg::OPN_BEQ;
      end
      rv_isa_pkg::OP_JAL: begin
        op  = rv_isa_pkg::OPN_JAL;
        imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      rv_isa_pkg::OP_SYSTEM: begin
        // ECALL only, all upper bits zero.
        if (insn[31:7] == 25'd0) op = rv_isa_pkg::OPN_HALT;
      end
      default: op = rv_isa_pkg::OPN_NOP;
    endcase
  end

endmodule

/* design/mem_arbiter.sv */
/*
  Fixed-priority arbiter for the single memory port.
  The external port always wins. Grants are combinational from the
  requests, rvalid follows a read grant by one cycle.
*/
`timescale 1ns/1ps

module mem_arbiter (
  input  logic        clk,
  input  logic        rst,
  input  logic        ext_req,
  input  logic        ext_we,
  input  logic [31:0] ext_addr,
  input  logic [31:0] ext_wdata,
  output logic        ext_gnt,
  output logic        ext_rvalid,
  input  logic        core_req,
  input  logic        core_we,
  input  logic [31:0] core_addr,
  input  logic [31:0] core_wdata,
  output logic        core_gnt,
  output logic        core_rvalid,
  output logic        mem_en,
  output logic        mem_we,
  output logic [31:0] mem_addr,
  output logic [31:0] mem_wdata
);
  mem_bus_pkg::requester_t owner;
  mem_bus_pkg::requester_t rd_owner;
  logic                    rd_pending;

  assign owner    = ext_req ? mem_bus_pkg::REQ_EXT : mem_bus_pkg::REQ_CORE;
  assign ext_gnt  = ext_req;
  assign core_gnt = core_req && !ext_req;

  // Forward the owner's access.
  assign mem_en    = ext_req || core_req;
  assign mem_we    = (owner == mem_bus_pkg::REQ_EXT) ? ext_we    : core_we;
  assign mem_addr  = (owner == mem_bus_pkg::REQ_EXT) ? ext_addr  : core_addr;
  assign mem_wdata = (owner == mem_bus_pkg::REQ_EXT) ? ext_wdata : core_wdata;

  // Read data comes back next cycle, so remember who read.
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_pending <= 1'b0;
      rd_owner   <= mem_bus_pkg::REQ_EXT;
    end else begin
      rd_pending <= mem_en && !mem_we;
      rd_owner   <= owner;
    end
  end

  assign ext_rvalid  = rd_pending && (rd_owner == mem_bus_pkg::REQ_EXT);
  assign core_rvalid = rd_pending && (rd_owner == mem_bus_pkg::REQ_CORE);

endmodule

/* design/mem_bus_pkg.sv */
/*
  Shared memory bus definitions.
  One peer owns the memory in a cycle, either the external port or the core.
*/
package mem_bus_pkg;

  // Owner of the memory in the current cycle.
  // The external port always wins when both request.
  typedef enum logic {
    REQ_EXT  = 1'b0,
    REQ_CORE = 1'b1
  } requester_t;

endpackage

/* design/reg_file.sv */
/*
  General register file, 32 x 32 bits.
  Two asynchronous read ports and one write port.
  x0 reads as zero and ignores writes. Reset clears every register.
*/
`timescale 1ns/1ps

module reg_file (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_isa_pkg::reg_addr_t rs1,
  input  rv_isa_pkg::reg_addr_t rs2,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data,
  input  logic                  we,
  input  rv_isa_pkg::reg_addr_t rd,
  input  rv_isa_pkg::word_t     rd_data
);
  rv_isa_pkg::word_t regs [32];

  // Reads see the old value in a write cycle.
  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

/* design/rv_isa_pkg.sv */
/*
  RV32 subset used by the core and its testbench.
  Only the opcodes below are decoded. Every other encoding runs as a no-op.
  All memory accesses are whole words.
*/
package rv_isa_pkg;

  // Widths with a meaning of their own.
  typedef logic [31:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;

  // --------------------
  // Major opcodes, bits 6:0.
  localparam opcode_t OP_LUI     = 7'b0110111;
  localparam opcode_t OP_REG_IMM = 7'b0010011;
  localparam opcode_t OP_REG_REG = 7'b0110011;
  localparam opcode_t OP_LOAD    = 7'b0000011;
  localparam opcode_t OP_STORE   = 7'b0100011;
  localparam opcode_t OP_BRANCH  = 7'b1100011;
  localparam opcode_t OP_JAL     = 7'b1101111;
  localparam opcode_t OP_SYSTEM  = 7'b1110011;

  // Function codes in bits 31:25.
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;
  localparam logic [6:0] FUNCT7_SUB    = 7'b0100000;

  // --------------------
  // Operation after decode.
  typedef enum logic [3:0] {
    OPN_NOP, OPN_LUI, OPN_ADDI, OPN_ADD, OPN_SUB, OPN_LW, OPN_SW,
    OPN_BEQ, OPN_JAL, OPN_DIV, OPN_DIVU, OPN_REM, OPN_REMU, OPN_HALT
  } op_t;

endpackage

/* design/unified_mem.sv */
/*
  Single-port synchronous word memory, program and data together.
  Address bits 1:0 are ignored. MEM_WORDS should be a power of two,
  higher address bits wrap. Read data appears one cycle after enable.
*/
`timescale 1ns/1ps

module unified_mem #(
  parameter int MEM_WORDS = 1024
) (
  input  logic        clk,
  input  logic        mem_en,
  input  logic        mem_we,
  input  logic [31:0] mem_addr,
  input  logic [31:0] mem_wdata,
  output logic [31:0] mem_rdata
);
  localparam int IDX_W = $clog2(MEM_WORDS);

  logic [31:0]      mem [MEM_WORDS];
  logic [IDX_W-1:0] idx;

  // Word index.
  assign idx = mem_addr[IDX_W+1:2];

  // A write cycle leaves the read data unchanged.
  always_ff @(posedge clk) begin
    if (mem_en && mem_we) begin
      mem[idx] <= mem_wdata;
    end else if (mem_en) begin
      mem_rdata <= mem[idx];
    end
  end

endmodule

/* run.sh */
#!/bin/sh
# Build with Verilator, run the testbench, and look for the pass line in the log.
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_cpu -o sim_cpu &&
  ./obj_dir/sim_cpu +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Simulation passed" sim.log || exit 1

/* tb.f */
design/rv_isa_pkg.sv
design/mem_bus_pkg.sv
design/insn_decode.sv
design/reg_file.sv
design/divider.sv
design/core_control.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/cpu_top.sv
tests/cpu_properties.sv
tests/tb_cpu.sv

/* tests/cpu_properties.sv */
/*
  Concurrent checks on the memory arbiter, attached with bind.
  Failures are counted in fail_count so that the testbench can see them.
  Checks are off while rst is high.
*/
`timescale 1ns/1ps

module cpu_properties (
  input logic clk,
  input logic rst,
  input logic ext_req,
  input logic ext_we,
  input logic core_we,
  input logic ext_gnt,
  input logic core_gnt,
  input logic ext_rvalid,
  input logic core_rvalid
);
  mem_bus_pkg::requester_t gnt_peer;
  int                      fail_count = 0;

  // Peer that owns the current grant.
  assign gnt_peer = ext_gnt ? mem_bus_pkg::REQ_EXT : mem_bus_pkg::REQ_CORE;

  // Only one peer reaches the memory per cycle.
  grants_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(ext_gnt && core_gnt))
    else begin
      $error("both grants high in one cycle");
      fail_count++;
    end

  // The external port always wins.
  ext_priority: assert property (@(posedge clk) disable iff (rst)
    ext_req |-> !core_gnt)
    else begin
      $error("core granted while the external port requests");
      fail_count++;
    end

  // A read grant returns rvalid to the same peer one cycle later.
  rvalid_follows_read: assert property (@(posedge clk) disable iff (rst)
    ((ext_gnt && !ext_we) || (core_gnt && !core_we)) |=>
    (($past(gnt_peer) == mem_bus_pkg::REQ_EXT) ? (ext_rvalid && !core_rvalid)
                                                : (core_rvalid && !ext_rvalid)))
    else begin
      $error("read grant without matching rvalid");
      fail_count++;
    end

endmodule

bind mem_arbiter cpu_properties u_props (
  .clk(clk), .rst(rst), .ext_req(ext_req), .ext_we(ext_we), .core_we(core_we),
  .ext_gnt(ext_gnt), .core_gnt(core_gnt),
  .ext_rvalid(ext_rvalid), .core_rvalid(core_rvalid)
);

/* tests/tb_cpu.sv */
/*
  Testbench for cpu_top. Builds one program in memory through the external
  port, runs it to ECALL while reading memory in parallel, then reads the
  result area back. Program at 0x000, divide operands at 0x400, results
  from 0x500, spare words at 0x700. All addresses fit a 12-bit offset.
*/
`timescale 1ns/1ps

module tb_cpu;
  logic              clk;
  logic              rst;
  logic              run;
  logic              halt;
  logic              ext_req;
  logic              ext_we;
  rv_isa_pkg::word_t ext_addr;
  rv_isa_pkg::word_t ext_wdata;
  logic              ext_gnt;
  logic              ext_rvalid;
  rv_isa_pkg::word_t ext_rdata;

  // Program image, words loaded before run, and words expected after halt.
  rv_isa_pkg::insn_t prog [$];
  rv_isa_pkg::word_t init_mem [rv_isa_pkg::word_t];
  rv_isa_pkg::word_t expect_mem [rv_isa_pkg::word_t];
  rv_isa_pkg::word_t res_ptr;
  rv_isa_pkg::op_t   div_ops [4] = '{rv_isa_pkg::OPN_DIV, rv_isa_pkg::OPN_DIVU,
                                     rv_isa_pkg::OPN_REM, rv_isa_pkg::OPN_REMU};
  integer            seed = 32'h05ec_aa86;
  int                errors = 0;
  logic              prog_built = 1'b0;

  cpu_top #(
    .MEM_WORDS(1024)
  ) dut0 (
    .clk(clk), .rst(rst), .run(run), .halt(halt),
    .ext_req(ext_req), .ext_we(ext_we), .ext_addr(ext_addr), .ext_wdata(ext_wdata),
    .ext_gnt(ext_gnt), .ext_rvalid(ext_rvalid), .ext_rdata(ext_rdata)
  );

  always #50 clk = ~clk;

  // --------------------
  // Expected result of one operation, from the ISA rules.
  function automatic rv_isa_pkg::word_t ref_op(input rv_isa_pkg::op_t op,
                                               input rv_isa_pkg::word_t a,
                                               input rv_isa_pkg::word_t b);
    rv_isa_pkg::word_t ua;
    rv_isa_pkg::word_t ub;
    rv_isa_pkg::word_t q;
    rv_isa_pkg::word_t r;
    logic              sa;
    logic              sb;
    sa = (op == rv_isa_pkg::OPN_DIV || op == rv_isa_pkg::OPN_REM) && a[31];
    sb = (op == rv_isa_pkg::OPN_DIV || op == rv_isa_pkg::OPN_REM) && b[31];
    ua = sa ? -a : a;
    ub = sb ? -b : b;
    // Divide by zero gives all ones and keeps the dividend as remainder.
    if (ub == '0) begin
      q = '1;
      r = ua;
    end else begin
      q = ua / ub;
      r = ua % ub;
      if (sa != sb) q = -q;
    end
    if (sa) r = -r;
    case (op)
      rv_isa_pkg::OPN_LUI:  return b;
      rv_isa_pkg::OPN_ADDI: return a + b;
      rv_isa_pkg::OPN_ADD:  return a + b;
      rv_isa_pkg::OPN_SUB:  return a - b;
      rv_isa_pkg::OPN_DIV:  return q;
      rv_isa_pkg::OPN_DIVU: return q;
      rv_isa_pkg::OPN_REM:  return r;
      rv_isa_pkg::OPN_REMU: return r;
      default:              return '0;
    endcase
  endfunction

  // Background value of result words. Uses every address bit.
  function automatic rv_isa_pkg::word_t fill_word(input rv_isa_pkg::word_t addr);
    return addr ^ 32'h5a5a_c3c3;
  endfunction

  // --------------------
  // RV32 instruction encoders.
  function automatic rv_isa_pkg::insn_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                              input rv_isa_pkg::reg_addr_t rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG_REG};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_i(input rv_isa_pkg::opcode_t opc,
                                              input logic [2:0] f3,
                                              input rv_isa_pkg::reg_addr_t rd, rs1,
                                              input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_beq(input rv_isa_pkg::reg_addr_t rs1, rs2,
                                                input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], rv_isa_pkg::OP_BRANCH};
  endfunction

  function automatic rv_isa_pkg::insn_t enc_jal(input rv_isa_pkg::reg_addr_t rd,
                                                input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OP_JAL};
  endfunction

  // SW of one register into the next result word, base x0.
  task automatic store_result(input rv_isa_pkg::reg_addr_t rs2, input rv_isa_pkg::word_t exp);
    prog.push_back({7'd0, rs2, 5'd0, 3'b010, 5'd0, rv_isa_pkg::OP_STORE}
                   | {res_ptr[11:5], 13'd0, res_ptr[4:0], 7'd0});
    expect_mem[res_ptr] = exp;
    init_mem[res_ptr]   = fill_word(res_ptr);
    res_ptr += 32'd4;
  endtask

  // A store that must never run leaves the fill value in place.
  task automatic skip_store(input rv_isa_pkg::reg_addr_t rs2);
    store_result(rs2, fill_word(res_ptr));
  endtask

  // --------------------
  task automatic build_program;
    rv_isa_pkg::word_t r1;
    rv_isa_pkg::word_t r2;
    rv_isa_pkg::word_t r3;
    rv_isa_pkg::word_t a;
    rv_isa_pkg::word_t b;
    rv_isa_pkg::word_t oaddr;
    rv_isa_pkg::word_t jal_pc;
    res_ptr = 32'h500;
    // Arithmetic block.
    r1 = ref_op(rv_isa_pkg::OPN_LUI, '0, 32'h1234_5000);
    r2 = ref_op(rv_isa_pkg::OPN_ADDI, r1, 32'h0000_0678);
    r3 = ref_op(rv_isa_pkg::OPN_ADDI, '0, 32'hffff_fffb);
    prog.push_back({20'h12345, 5'd1, rv_isa_pkg::OP_LUI});
    prog.push_back(enc_i(rv_isa_pkg::OP_REG_IMM, 3'b000, 5'd2, 5'd1, 12'h678));
    prog.push_back(enc_i(rv_isa_pkg::OP_REG_IMM, 3'b000, 5'd3, 5'd0, 12'hffb));
    prog.push_back(enc_r(7'd0, 3'b000, 5'd4, 5'd2, 5'd3));
    prog.push_back(enc_r(rv_isa_pkg::FUNCT7_SUB, 3'b000, 5'd5, 5'd3, 5'd2));
    store_result(5'd1, r1);
    store_result(5'd2, r2);
    store_result(5'd3, r3);
    store_result(5'd4, ref_op(rv_isa_pkg::OPN_ADD, r2, r3));
    store_result(5'd5, ref_op(rv_isa_pkg::OPN_SUB, r3, r2));
    // Divide block. Pair 0 divides by zero, pair 1 is the overflow case.
    for (int i = 0; i < 16; i++) begin
      a = $random(seed);
      b = $random(seed);
      if (i > 1 && i % 2 == 1) b = {{20{b[31]}}, b[31:20]};
      if (i == 0) b = '0;
      if (i == 1) begin
        a = 32'h8000_0000;
        b = 32'hffff_ffff;
      end
      oaddr = 32'h400 + rv_isa_pkg::word_t'(i * 8);
      init_mem[oaddr]         = a;
      init_mem[oaddr + 32'd4] = b;
      prog.push_back(enc_i(rv_isa_pkg::OP_LOAD, 3'b010, 5'd6, 5'd0, oaddr[11:0]));
      prog.push_back(enc_i(rv_isa_pkg::OP_LOAD, 3'b010, 5'd7, 5'd0, oaddr[11:0] + 12'd4));
      for (int k = 0; k < 4; k++) begin
        prog.push_back(enc_r(rv_isa_pkg::FUNCT7_MULDIV, 3'b100 | 3'(k), 5'd8, 5'd6, 5'd7));
        store_result(5'd8, ref_op(div_ops[k], a, b));
      end
    end
    // Control flow. Taken BEQ, not taken BEQ, then JAL over one store.
    prog.push_back(enc_i(rv_isa_pkg::OP_REG_IMM, 3'b000, 5'd9, 5'd0, 12'd7));
    prog.push_back(enc_i(rv_isa_pkg::OP_REG_IMM, 3'b000, 5'd10, 5'd0, 12'd7));
    prog.push_back(enc_beq(5'd9, 5'd10, 13'd8));
    skip_store(5'd9);
    prog.push_back(enc_beq(5'd9, 5'd0, 13'd8));
    store_result(5'd9, ref_op(rv_isa_pkg::OPN_ADDI, '0, 32'd7));
    jal_pc = rv_isa_pkg::word_t'(prog.size()) * 32'd4;
    prog.push_back(enc_jal(5'd12, 21'd8));
    skip_store(5'd9);
    store_result(5'd12, jal_pc + 32'd4);
    // ECALL, and a store behind it that must not run.
    prog.push_back(32'h0000_0073);
    skip_store(5'd9);
    foreach (prog[i]) init_mem[rv_isa_pkg::word_t'(i) * 32'd4] = prog[i];
  endtask

  // --------------------
  // External port access. Entered right after a falling edge.
  task automatic ext_write(input rv_isa_pkg::word_t addr, input rv_isa_pkg::word_t data);
    ext_req   = 1'b1;
    ext_we    = 1'b1;
    ext_addr  = addr;
    ext_wdata = data;
    @(posedge clk);
    while (!ext_gnt) @(posedge clk);
    @(negedge clk);
    ext_req = 1'b0;
    ext_we  = 1'b0;
  endtask

  task automatic ext_read(input rv_isa_pkg::word_t addr, output rv_isa_pkg::word_t data);
    ext_req  = 1'b1;
    ext_we   = 1'b0;
    ext_addr = addr;
    @(posedge clk);
    while (!ext_gnt) @(posedge clk);
    @(negedge clk);
    ext_req = 1'b0;
    // Data comes with rvalid in the cycle after the grant.
    while (!ext_rvalid) @(negedge clk);
    data = ext_rdata;
  endtask

  task automatic check_word(input rv_isa_pkg::word_t got, input rv_isa_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s read %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_halt(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s, halt is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------
  // Watchdog, sized from the program length.
  initial begin
    int limit;
    wait (prog_built);
    limit = prog.size() * 200;
    repeat (limit) @(posedge clk);
    $display("Run timed out after %0d cycles without finishing the tests", limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    rv_isa_pkg::word_t data;
    rv_isa_pkg::word_t addr;
    int                gap;
    int                k;
    clk       = 1'b0;
    rst       = 1'b1;
    run       = 1'b0;
    ext_req   = 1'b0;
    ext_we    = 1'b0;
    ext_addr  = '0;
    ext_wdata = '0;
    build_program();
    prog_built = 1'b1;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    check_halt(halt, 1'b0, "after reset");
    // Load everything, then read it back before run.
    foreach (init_mem[a]) ext_write(a, init_mem[a]);
    foreach (init_mem[a]) begin
      ext_read(a, data);
      check_word(data, init_mem[a], "preload readback");
    end
    // The core stays idle until run, so halt is still low here.
    check_halt(halt, 1'b0, "before run");
    run = 1'b1;
    // Program words are read while the core runs, with idle gaps for it.
    k = 0;
    while (!halt) begin
      addr = rv_isa_pkg::word_t'(k % prog.size()) * 32'd4;
      ext_read(addr, data);
      check_word(data, prog[k % prog.size()], "read during run");
      k++;
      gap = 1 + int'($unsigned($random(seed)) % 4);
      repeat (gap) @(negedge clk);
    end
    foreach (expect_mem[a]) begin
      ext_read(a, data);
      check_word(data, expect_mem[a], "result word");
    end
    // Port still works after halt.
    for (int i = 0; i < 8; i++) begin
      addr = 32'h700 + rv_isa_pkg::word_t'(i * 4);
      ext_write(addr, fill_word(addr) + 32'd1);
      ext_read(addr, data);
      check_word(data, fill_word(addr) + 32'd1, "write after halt");
    end
    repeat (10) @(negedge clk);
    check_halt(halt, 1'b1, "halt held");
    $display("Errors: %0d mismatches, %0d assertion failures",
             errors, dut0.u_arb.u_props.fail_count);
    if (errors == 0 && dut0.u_arb.u_props.fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
